// ==== id_pkg.sv ====
package id_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 12;

    localparam logic [reg_addr_w-1:0] link_reg = 5'd31;

    // major opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // function field under op_special
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_sllv = 6'h04;
    localparam logic [5:0] fn_srlv = 6'h06;
    localparam logic [5:0] fn_srav = 6'h07;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_jalr = 6'h09;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    // rt codes of the regimm group
    localparam logic [reg_addr_w-1:0] rt_bltz = 5'd0;
    localparam logic [reg_addr_w-1:0] rt_bgez = 5'd1;

    typedef union packed {
        struct packed {
            logic [5:0]            opcode;
            logic [reg_addr_w-1:0] rs;
            logic [reg_addr_w-1:0] rt;
            logic [reg_addr_w-1:0] rd;
            logic [4:0]            sa;
            logic [5:0]            func;
        } r;
        struct packed {
            logic [5:0]            opcode;
            logic [reg_addr_w-1:0] rs;
            logic [reg_addr_w-1:0] rt;
            logic [15:0]           imm;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] index;
        } j;
    } inst_word_u;

    typedef struct packed {
        logic id_hold;
        logic if_hold;
    } stall_t;

    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] pc;
    } if_id_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [data_w-1:0]     wdata;
    } fwd_t;

    typedef struct packed {
        logic alu_add;
        logic alu_sub;
        logic alu_slt;
        logic alu_sltu;
        logic alu_and;
        logic alu_nor;
        logic alu_or;
        logic alu_xor;
        logic alu_sll;
        logic alu_srl;
        logic alu_sra;
        logic alu_lui;
    } alu_op_t;

    // src1_sel bits: 0 rs, 1 pc, 2 sa
    // src2_sel bits: 0 rt, 1 sign imm, 2 const 8, 3 zero imm
    typedef struct packed {
        alu_op_t               alu_op;
        logic [2:0]            src1_sel;
        logic [3:0]            src2_sel;
        logic                  mem_en;
        logic                  mem_we;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
    } id_ctrl_t;

    typedef struct packed {
        logic [data_w-1:0] pc;
        inst_word_u        inst;
        id_ctrl_t          ctrl;
        logic [data_w-1:0] rdata1;
        logic [data_w-1:0] rdata2;
    } id_to_ex_t;

    typedef struct packed {
        logic              taken;
        logic [data_w-1:0] target;
    } br_t;

endpackage

// ==== id_fetch_latch.sv ====
`timescale 1ns/100ps

module id_fetch_latch (
    input  logic                      clk,
    input  logic                      rst,
    input  id_pkg::stall_t            stall,
    input  id_pkg::if_id_t            if_to_id,
    input  logic [id_pkg::data_w-1:0] inst_sram_rdata,
    output id_pkg::if_id_t            id_pc,
    output id_pkg::inst_word_u        inst
);
    import id_pkg::*;

    if_id_t            id_pc_r;
    logic              held;
    logic [data_w-1:0] held_word;
    logic [data_w-1:0] live_word;

    // sram answers the pc latched on the previous edge
    assign live_word = id_pc_r.valid ? inst_sram_rdata : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_pc_r <= '0;
            held    <= 1'b0;
        end else if (stall.if_hold && !stall.id_hold) begin
            // bubble into decode
            id_pc_r <= '0;
            held    <= 1'b0;
        end else if (!stall.if_hold) begin
            id_pc_r <= if_to_id;
            held    <= 1'b0;
        end else if (stall.id_hold) begin
            held <= 1'b1;
        end
    end

    // grab the word once, on entry to the hold
    always_ff @(posedge clk) begin
        if (stall.if_hold && stall.id_hold && !held) begin
            held_word <= live_word;
        end
    end

    assign id_pc = id_pc_r;
    assign inst  = held ? held_word : live_word;

endmodule

// ==== id_control.sv ====
`timescale 1ns/100ps

module id_control (
    input  id_pkg::inst_word_u inst,
    input  id_pkg::fwd_t       ex_fwd,
    input  logic               ex_is_load,
    output id_pkg::id_ctrl_t   ctrl,
    output logic               stallreq
);
    import id_pkg::*;

    logic special;
    logic sa_zero;
    logic rs_zero;
    logic inst_addu, inst_subu, inst_and, inst_or, inst_xor, inst_nor;
    logic inst_slt, inst_sltu;
    logic inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
    logic inst_addiu, inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_slti, inst_sltiu;
    logic inst_lw, inst_sw, inst_j, inst_jal, inst_jalr;
    logic reg_alu;
    logic imm_alu;
    logic shift_imm;
    logic [alu_op_w-1:0] alu_bits;

    assign special = inst.r.opcode == op_special;
    assign sa_zero = inst.r.sa == '0;
    assign rs_zero = inst.r.rs == '0;

    // register alu, sa must be zero
    assign inst_addu = special && sa_zero && inst.r.func == fn_addu;
    assign inst_subu = special && sa_zero && inst.r.func == fn_subu;
    assign inst_and  = special && sa_zero && inst.r.func == fn_and;
    assign inst_or   = special && sa_zero && inst.r.func == fn_or;
    assign inst_xor  = special && sa_zero && inst.r.func == fn_xor;
    assign inst_nor  = special && sa_zero && inst.r.func == fn_nor;
    assign inst_slt  = special && sa_zero && inst.r.func == fn_slt;
    assign inst_sltu = special && sa_zero && inst.r.func == fn_sltu;
    assign inst_sllv = special && sa_zero && inst.r.func == fn_sllv;
    assign inst_srlv = special && sa_zero && inst.r.func == fn_srlv;
    assign inst_srav = special && sa_zero && inst.r.func == fn_srav;

    // shift by sa, rs must be zero
    assign inst_sll = special && rs_zero && inst.r.func == fn_sll;
    assign inst_srl = special && rs_zero && inst.r.func == fn_srl;
    assign inst_sra = special && rs_zero && inst.r.func == fn_sra;

    assign inst_jalr = special && sa_zero && inst.r.rt == '0 && inst.r.func == fn_jalr;

    assign inst_addiu = inst.i.opcode == op_addiu;
    assign inst_andi  = inst.i.opcode == op_andi;
    assign inst_ori   = inst.i.opcode == op_ori;
    assign inst_xori  = inst.i.opcode == op_xori;
    assign inst_lui   = inst.i.opcode == op_lui;
    assign inst_slti  = inst.i.opcode == op_slti;
    assign inst_sltiu = inst.i.opcode == op_sltiu;
    assign inst_lw    = inst.i.opcode == op_lw;
    assign inst_sw    = inst.i.opcode == op_sw;
    assign inst_j     = inst.j.opcode == op_j;
    assign inst_jal   = inst.j.opcode == op_jal;

    assign shift_imm = inst_sll | inst_srl | inst_sra;
    assign reg_alu   = inst_addu | inst_subu | inst_and | inst_or | inst_xor | inst_nor
                     | inst_slt | inst_sltu | inst_sllv | inst_srlv | inst_srav | shift_imm;
    assign imm_alu   = inst_addiu | inst_andi | inst_ori | inst_xori | inst_lui
                     | inst_slti | inst_sltiu;

    // same order as alu_op_t
    assign alu_bits = {
        inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal | inst_jalr,
        inst_subu,
        inst_slt | inst_slti,
        inst_sltu | inst_sltiu,
        inst_and | inst_andi,
        inst_nor,
        inst_or | inst_ori,
        inst_xor | inst_xori,
        inst_sll | inst_sllv,
        inst_srl | inst_srlv,
        inst_sra | inst_srav,
        inst_lui
    };

    always_comb begin
        ctrl.alu_op = alu_bits;

        ctrl.src1_sel[0] = (reg_alu & ~shift_imm) | imm_alu | inst_lw | inst_sw | inst_jalr;
        ctrl.src1_sel[1] = inst_jal | inst_jalr;
        ctrl.src1_sel[2] = shift_imm;

        ctrl.src2_sel[0] = reg_alu;
        ctrl.src2_sel[1] = inst_addiu | inst_slti | inst_sltiu | inst_lw | inst_sw | inst_lui;
        ctrl.src2_sel[2] = inst_j | inst_jal | inst_jalr;
        ctrl.src2_sel[3] = inst_andi | inst_ori | inst_xori;

        ctrl.mem_en = inst_lw | inst_sw;
        ctrl.mem_we = inst_sw;

        // every alu user writes back, except the store
        ctrl.rf_we = (|alu_bits) & ~inst_sw;

        if (reg_alu || inst_jalr) begin
            ctrl.rf_waddr = inst.r.rd;
        end else if (imm_alu || inst_lw) begin
            ctrl.rf_waddr = inst.i.rt;
        end else if (inst_jal) begin
            ctrl.rf_waddr = link_reg;
        end else begin
            ctrl.rf_waddr = '0;
        end
    end

    // load in ex feeds this instruction
    assign stallreq = ex_is_load && ex_fwd.waddr != '0
                   && (ex_fwd.waddr == inst.r.rs || ex_fwd.waddr == inst.r.rt);

endmodule

// ==== id_regfile.sv ====
`timescale 1ns/100ps

module id_regfile (
    input  logic                          clk,
    input  logic [id_pkg::reg_addr_w-1:0] raddr1,
    input  logic [id_pkg::reg_addr_w-1:0] raddr2,
    input  id_pkg::fwd_t                  ex_fwd,
    input  id_pkg::fwd_t                  mem_fwd,
    input  id_pkg::fwd_t                  wb_fwd,
    output logic [id_pkg::data_w-1:0]     rdata1,
    output logic [id_pkg::data_w-1:0]     rdata2
);
    import id_pkg::*;

    logic [data_w-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (wb_fwd.we && wb_fwd.waddr != '0) begin
            regs[wb_fwd.waddr] <= wb_fwd.wdata;
        end
    end

    // youngest producer wins
    function automatic logic [data_w-1:0] read_port(
        input logic [reg_addr_w-1:0] addr,
        input fwd_t                  ex_src,
        input fwd_t                  mem_src,
        input fwd_t                  wb_src,
        input logic [data_w-1:0]     stored
    );
        logic [data_w-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (ex_src.we && ex_src.waddr == addr) begin
            val = ex_src.wdata;
        end else if (mem_src.we && mem_src.waddr == addr) begin
            val = mem_src.wdata;
        end else if (wb_src.we && wb_src.waddr == addr) begin
            val = wb_src.wdata;
        end else begin
            val = stored;
        end
        return val;
    endfunction

    assign rdata1 = read_port(raddr1, ex_fwd, mem_fwd, wb_fwd, regs[raddr1]);
    assign rdata2 = read_port(raddr2, ex_fwd, mem_fwd, wb_fwd, regs[raddr2]);

endmodule

// ==== id_branch_unit.sv ====
`timescale 1ns/100ps

module id_branch_unit (
    input  id_pkg::inst_word_u        inst,
    input  id_pkg::if_id_t            id_pc,
    input  logic [id_pkg::data_w-1:0] rdata1,
    input  logic [id_pkg::data_w-1:0] rdata2,
    output id_pkg::br_t               br
);
    import id_pkg::*;

    logic inst_beq, inst_bne, inst_bgez, inst_bltz, inst_bgtz, inst_blez;
    logic inst_j, inst_jal, inst_jr, inst_jalr;
    logic is_branch;
    logic ops_eq;
    logic rs_neg;
    logic rs_zero;
    logic cond_met;
    logic [data_w-1:0] pc_plus_4;
    logic [data_w-1:0] br_off;

    assign inst_beq  = inst.i.opcode == op_beq;
    assign inst_bne  = inst.i.opcode == op_bne;
    assign inst_bgez = inst.i.opcode == op_regimm && inst.i.rt == rt_bgez;
    assign inst_bltz = inst.i.opcode == op_regimm && inst.i.rt == rt_bltz;
    assign inst_bgtz = inst.i.opcode == op_bgtz && inst.i.rt == '0;
    assign inst_blez = inst.i.opcode == op_blez && inst.i.rt == '0;
    assign inst_j    = inst.j.opcode == op_j;
    assign inst_jal  = inst.j.opcode == op_jal;
    assign inst_jr   = inst.r.opcode == op_special && inst.r.rt == '0 && inst.r.rd == '0
                    && inst.r.sa == '0 && inst.r.func == fn_jr;
    assign inst_jalr = inst.r.opcode == op_special && inst.r.rt == '0
                    && inst.r.sa == '0 && inst.r.func == fn_jalr;

    assign is_branch = inst_beq | inst_bne | inst_bgez | inst_bltz | inst_bgtz | inst_blez;

    assign ops_eq  = rdata1 == rdata2;
    assign rs_neg  = rdata1[data_w-1];
    assign rs_zero = rdata1 == '0;

    assign cond_met = (inst_beq & ops_eq) | (inst_bne & ~ops_eq)
                    | (inst_bgez & ~rs_neg) | (inst_bltz & rs_neg)
                    | (inst_bgtz & ~rs_neg & ~rs_zero) | (inst_blez & (rs_neg | rs_zero));

    assign pc_plus_4 = id_pc.pc + 32'd4;
    assign br_off    = {{14{inst.i.imm[15]}}, inst.i.imm, 2'b00};

    always_comb begin
        br.taken = cond_met | inst_j | inst_jal | inst_jr | inst_jalr;
        if (!br.taken) begin
            br.target = '0;
        end else if (is_branch) begin
            br.target = pc_plus_4 + br_off;
        end else if (inst_j || inst_jal) begin
            br.target = {pc_plus_4[31:28], inst.j.index, 2'b00};
        end else begin
            br.target = rdata1;
        end
    end

endmodule

// ==== id_stage.sv ====
`timescale 1ns/100ps

module id_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  id_pkg::stall_t            stall,
    input  id_pkg::if_id_t            if_to_id,
    input  logic [id_pkg::data_w-1:0] inst_sram_rdata,
    input  id_pkg::fwd_t              ex_fwd,
    input  id_pkg::fwd_t              mem_fwd,
    input  id_pkg::fwd_t              wb_fwd,
    input  logic                      ex_is_load,
    output id_pkg::id_to_ex_t         id_to_ex,
    output id_pkg::br_t               br,
    output logic                      stallreq
);
    import id_pkg::*;

    if_id_t            id_pc;
    inst_word_u        inst;
    id_ctrl_t          ctrl;
    logic [data_w-1:0] rdata1;
    logic [data_w-1:0] rdata2;

    id_fetch_latch fetch_latch_inst (
        .clk             (clk),
        .rst             (rst),
        .stall           (stall),
        .if_to_id        (if_to_id),
        .inst_sram_rdata (inst_sram_rdata),
        .id_pc           (id_pc),
        .inst            (inst)
    );

    id_control control_inst (
        .inst       (inst),
        .ex_fwd     (ex_fwd),
        .ex_is_load (ex_is_load),
        .ctrl       (ctrl),
        .stallreq   (stallreq)
    );

    id_regfile regfile_inst (
        .clk     (clk),
        .raddr1  (inst.r.rs),
        .raddr2  (inst.r.rt),
        .ex_fwd  (ex_fwd),
        .mem_fwd (mem_fwd),
        .wb_fwd  (wb_fwd),
        .rdata1  (rdata1),
        .rdata2  (rdata2)
    );

    id_branch_unit branch_unit_inst (
        .inst   (inst),
        .id_pc  (id_pc),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .br     (br)
    );

    always_comb begin
        id_to_ex.pc     = id_pc.pc;
        id_to_ex.inst   = inst;
        id_to_ex.ctrl   = ctrl;
        id_to_ex.rdata1 = rdata1;
        id_to_ex.rdata2 = rdata2;
    end

endmodule

// ==== tb_id_stage.sv ====
`timescale 1ns/100ps

module tb_id_stage;
    import id_pkg::*;

    localparam int max_cycles = 2000;

    logic       clk;
    logic       rst;
    stall_t     stall;
    if_id_t     if_to_id;
    logic [31:0] inst_sram_rdata;
    fwd_t       ex_fwd;
    fwd_t       mem_fwd;
    fwd_t       wb_fwd;
    logic       ex_is_load;
    id_to_ex_t  id_to_ex;
    br_t        br;
    logic       stallreq;

    int          errors;
    int          checks;
    int          cycles = 0;
    logic [31:0] seed;
    logic [31:0] model [32];

    localparam logic [4:0] ra = 5'd3;
    localparam logic [4:0] rb = 5'd4;
    localparam logic [4:0] rc = 5'd5;
    localparam logic [4:0] r0 = 5'd0;

    id_stage id_stage_inst (
        .clk             (clk),
        .rst             (rst),
        .stall           (stall),
        .if_to_id        (if_to_id),
        .inst_sram_rdata (inst_sram_rdata),
        .ex_fwd          (ex_fwd),
        .mem_fwd         (mem_fwd),
        .wb_fwd          (wb_fwd),
        .ex_is_load      (ex_is_load),
        .id_to_ex        (id_to_ex),
        .br              (br),
        .stallreq        (stallreq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, tests did not finish", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sa,
                                           input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // pc goes in one cycle, its word the next
    task automatic issue(input logic [31:0] pc, input logic [31:0] word);
        @(posedge clk);
        if_to_id.valid <= 1'b1;
        if_to_id.pc    <= pc;
        @(posedge clk);
        inst_sram_rdata <= word;
        @(negedge clk);
    endtask

    task automatic decode_case(input string name, input logic [31:0] word,
                               input logic [11:0] alu, input logic [2:0] s1,
                               input logic [3:0] s2, input logic men, input logic mwe,
                               input logic rfwe, input logic [4:0] wa);
        logic [31:0] pc;
        pc = next_rand() & 32'hffff_fffc;
        issue(pc, word);
        check_value({name, " pc"}, id_to_ex.pc, pc);
        check_value({name, " inst"}, id_to_ex.inst, word);
        check_value({name, " alu_op"}, 32'(id_to_ex.ctrl.alu_op), 32'(alu));
        check_value({name, " src1_sel"}, 32'(id_to_ex.ctrl.src1_sel), 32'(s1));
        check_value({name, " src2_sel"}, 32'(id_to_ex.ctrl.src2_sel), 32'(s2));
        check_value({name, " mem_en"}, 32'(id_to_ex.ctrl.mem_en), 32'(men));
        check_value({name, " mem_we"}, 32'(id_to_ex.ctrl.mem_we), 32'(mwe));
        check_value({name, " rf_we"}, 32'(id_to_ex.ctrl.rf_we), 32'(rfwe));
        check_value({name, " rf_waddr"}, 32'(id_to_ex.ctrl.rf_waddr), 32'(wa));
    endtask

    task automatic decode_table();
        int start;
        start = errors;
        decode_case("addu", r_word(ra, rb, rc, r0, 6'h21), 12'h800, 3'b001, 4'b0001,
                    1'b0, 1'b0, 1'b1, rc);
        decode_case("subu", r_word(ra, rb, rc, r0, 6'h23), 12'h400, 3'b001, 4'b0001,
                    1'b0, 1'b0, 1'b1, rc);
        decode_case("and", r_word(ra, rb, rc, r0, 6'h24), 12'h080, 3'b001, 4'b0001,
                    1'b0, 1'b0, 1'b1, rc);
        decode_case("or", r_word(ra, rb, rc, r0, 6'h25), 12'h020, 3'b001, 4'b0001,
                    1'b0, 1'b0, 1'b1, rc);
        decode_case("xor", r_word(ra, rb, rc, r0, 6'h26), 12'h010, 3'b001, 4'b0001,
                    1'b0, 1'b0, 1'b1, rc);
        decode_case("nor", r_word(ra, rb, rc, r0, 6'h27), 12'h040, 3'b001, 4'b0001,
                    1'b0, 1'b0, 1'b1, rc);
        decode_case("slt", r_word(ra, rb, rc, r0, 6'h2a), 12'h200, 3'b001, 4'b0001,
                    1'b0, 1'b0, 1'b1, rc);
        decode_case("sltu", r_word(ra, rb, rc, r0, 6'h2b), 12'h100, 3'b001, 4'b0001,
                    1'b0, 1'b0, 1'b1, rc);
        decode_case("sll", r_word(r0, rb, rc, 5'd7, 6'h00), 12'h008, 3'b100, 4'b0001,
                    1'b0, 1'b0, 1'b1, rc);
        decode_case("srl", r_word(r0, rb, rc, 5'd7, 6'h02), 12'h004, 3'b100, 4'b0001,
                    1'b0, 1'b0, 1'b1, rc);
        decode_case("sra", r_word(r0, rb, rc, 5'd7, 6'h03), 12'h002, 3'b100, 4'b0001,
                    1'b0, 1'b0, 1'b1, rc);
        decode_case("sllv", r_word(ra, rb, rc, r0, 6'h04), 12'h008, 3'b001, 4'b0001,
                    1'b0, 1'b0, 1'b1, rc);
        decode_case("srlv", r_word(ra, rb, rc, r0, 6'h06), 12'h004, 3'b001, 4'b0001,
                    1'b0, 1'b0, 1'b1, rc);
        decode_case("srav", r_word(ra, rb, rc, r0, 6'h07), 12'h002, 3'b001, 4'b0001,
                    1'b0, 1'b0, 1'b1, rc);
        decode_case("addiu", i_word(6'h09, ra, rb, 16'h8001), 12'h800, 3'b001, 4'b0010,
                    1'b0, 1'b0, 1'b1, rb);
        decode_case("slti", i_word(6'h0a, ra, rb, 16'h0011), 12'h200, 3'b001, 4'b0010,
                    1'b0, 1'b0, 1'b1, rb);
        decode_case("sltiu", i_word(6'h0b, ra, rb, 16'h0022), 12'h100, 3'b001, 4'b0010,
                    1'b0, 1'b0, 1'b1, rb);
        decode_case("andi", i_word(6'h0c, ra, rb, 16'hf0f0), 12'h080, 3'b001, 4'b1000,
                    1'b0, 1'b0, 1'b1, rb);
        decode_case("ori", i_word(6'h0d, ra, rb, 16'h0f0f), 12'h020, 3'b001, 4'b1000,
                    1'b0, 1'b0, 1'b1, rb);
        decode_case("xori", i_word(6'h0e, ra, rb, 16'h1234), 12'h010, 3'b001, 4'b1000,
                    1'b0, 1'b0, 1'b1, rb);
        decode_case("lui", i_word(6'h0f, r0, rb, 16'hbeef), 12'h001, 3'b001, 4'b0010,
                    1'b0, 1'b0, 1'b1, rb);
        decode_case("lw", i_word(6'h23, ra, rb, 16'h0040), 12'h800, 3'b001, 4'b0010,
                    1'b1, 1'b0, 1'b1, rb);
        decode_case("sw", i_word(6'h2b, ra, rb, 16'h0044), 12'h800, 3'b001, 4'b0010,
                    1'b1, 1'b1, 1'b0, r0);
        decode_case("j", {6'h02, 26'h0123456}, 12'h000, 3'b000, 4'b0100,
                    1'b0, 1'b0, 1'b0, r0);
        decode_case("jal", {6'h03, 26'h0123456}, 12'h800, 3'b010, 4'b0100,
                    1'b0, 1'b0, 1'b1, 5'd31);
        decode_case("jalr", r_word(ra, r0, rc, r0, 6'h09), 12'h800, 3'b011, 4'b0100,
                    1'b0, 1'b0, 1'b1, rc);
        decode_case("jr", r_word(ra, r0, r0, r0, 6'h08), 12'h000, 3'b000, 4'b0000,
                    1'b0, 1'b0, 1'b0, r0);
        decode_case("beq", i_word(6'h04, ra, rb, 16'h0010), 12'h000, 3'b000, 4'b0000,
                    1'b0, 1'b0, 1'b0, r0);
        decode_case("bne", i_word(6'h05, ra, rb, 16'h0010), 12'h000, 3'b000, 4'b0000,
                    1'b0, 1'b0, 1'b0, r0);
        decode_case("bgez", i_word(6'h01, ra, 5'd1, 16'h0010), 12'h000, 3'b000, 4'b0000,
                    1'b0, 1'b0, 1'b0, r0);
        decode_case("bgtz", i_word(6'h07, ra, r0, 16'h0010), 12'h000, 3'b000, 4'b0000,
                    1'b0, 1'b0, 1'b0, r0);
        decode_case("blez", i_word(6'h06, ra, r0, 16'h0010), 12'h000, 3'b000, 4'b0000,
                    1'b0, 1'b0, 1'b0, r0);
        decode_case("bltz", i_word(6'h01, ra, r0, 16'h0010), 12'h000, 3'b000, 4'b0000,
                    1'b0, 1'b0, 1'b0, r0);
        $display("test decode_table done, %0d errors", errors - start);
    endtask

    task automatic read_pair(input string name, input logic [4:0] a, input logic [4:0] b,
                             input logic [31:0] exp1, input logic [31:0] exp2);
        issue(next_rand() & 32'hffff_fffc, r_word(a, b, rc, r0, 6'h21));
        check_value({name, " rdata1"}, id_to_ex.rdata1, exp1);
        check_value({name, " rdata2"}, id_to_ex.rdata2, exp2);
    endtask

    task automatic regfile_bypass();
        int          start;
        logic [31:0] tmp;
        logic [31:0] xe;
        logic [31:0] xm;
        logic [31:0] xw;
        start = errors;
        model[0] = '0;
        for (int i = 1; i < 32; i++) begin
            tmp = next_rand();
            @(posedge clk);
            wb_fwd <= '{1'b1, 5'(i), tmp};
            model[i] = tmp;
        end
        @(posedge clk);
        wb_fwd.we <= 1'b0;
        for (int k = 0; k < 8; k++) begin
            logic [4:0] a;
            logic [4:0] b;
            tmp = next_rand();
            a = tmp[12:8];
            b = tmp[20:16];
            read_pair("readback", a, b, model[a], model[b]);
        end
        xe = next_rand();
        xm = next_rand();
        xw = next_rand();
        @(posedge clk);
        ex_fwd  <= '{1'b1, 5'd9, xe};
        mem_fwd <= '{1'b1, 5'd9, xm};
        wb_fwd  <= '{1'b1, 5'd9, xw};
        read_pair("bypass ex", 5'd9, 5'd9, xe, xe);
        @(posedge clk);
        ex_fwd.we <= 1'b0;
        @(negedge clk);
        check_value("bypass mem rdata1", id_to_ex.rdata1, xm);
        // register 9 already holds xw, so only the bypass can return the new word
        @(posedge clk);
        mem_fwd.we   <= 1'b0;
        wb_fwd.wdata <= ~xw;
        @(negedge clk);
        check_value("bypass wb rdata2", id_to_ex.rdata2, ~xw);
        @(posedge clk);
        ex_fwd  <= '{1'b1, 5'd0, xe};
        mem_fwd <= '{1'b1, 5'd0, xm};
        wb_fwd  <= '{1'b1, 5'd0, xw};
        read_pair("zero reg", r0, r0, 32'd0, 32'd0);
        @(posedge clk);
        ex_fwd  <= '0;
        mem_fwd <= '0;
        wb_fwd  <= '0;
        $display("test regfile_bypass done, %0d errors", errors - start);
    endtask

    // kind 0 pc-relative branch, 1 jump by index, 2 jump by register
    task automatic branch_case(input string name, input logic [31:0] word, input int kind,
                               input logic [31:0] v1, input logic [31:0] v2,
                               input logic exp_taken);
        logic [31:0] pc;
        logic [31:0] pc4;
        logic [31:0] exp_target;
        pc  = next_rand() & 32'hffff_fffc;
        pc4 = pc + 32'd4;
        if (!exp_taken) begin
            exp_target = '0;
        end else if (kind == 0) begin
            exp_target = pc4 + (32'($signed(word[15:0])) << 2);
        end else if (kind == 1) begin
            exp_target = {pc4[31:28], word[25:0], 2'b00};
        end else begin
            exp_target = v1;
        end
        @(posedge clk);
        ex_fwd  <= '{1'b1, ra, v1};
        mem_fwd <= '{1'b1, rb, v2};
        issue(pc, word);
        check_value({name, " taken"}, 32'(br.taken), 32'(exp_taken));
        check_value({name, " target"}, br.target, exp_target);
    endtask

    task automatic branch_resolution();
        int          start;
        logic [31:0] v;
        logic [31:0] rnd;
        logic [15:0] imm;
        start = errors;
        v   = next_rand();
        rnd = next_rand();
        imm = rnd[31:16];
        branch_case("beq taken", i_word(6'h04, ra, rb, imm), 0, v, v, 1'b1);
        branch_case("beq not", i_word(6'h04, ra, rb, imm), 0, v, v + 1, 1'b0);
        branch_case("bne taken", i_word(6'h05, ra, rb, imm), 0, v, ~v, 1'b1);
        branch_case("bne not", i_word(6'h05, ra, rb, imm), 0, v, v, 1'b0);
        branch_case("bgez taken", i_word(6'h01, ra, 5'd1, imm), 0, 32'd0, v, 1'b1);
        branch_case("bgez not", i_word(6'h01, ra, 5'd1, imm), 0, -32'sd5, v, 1'b0);
        branch_case("bgtz taken", i_word(6'h07, ra, r0, imm), 0, 32'd5, v, 1'b1);
        branch_case("bgtz not", i_word(6'h07, ra, r0, imm), 0, 32'd0, v, 1'b0);
        branch_case("blez taken", i_word(6'h06, ra, r0, imm), 0, 32'd0, v, 1'b1);
        branch_case("blez not", i_word(6'h06, ra, r0, imm), 0, 32'd1, v, 1'b0);
        branch_case("bltz taken", i_word(6'h01, ra, r0, imm), 0, 32'hffff_ffff, v, 1'b1);
        branch_case("bltz not", i_word(6'h01, ra, r0, imm), 0, 32'd0, v, 1'b0);
        rnd = next_rand();
        branch_case("j", {6'h02, rnd[25:0]}, 1, v, v, 1'b1);
        rnd = next_rand();
        branch_case("jal", {6'h03, rnd[25:0]}, 1, v, v, 1'b1);
        branch_case("jr", r_word(ra, r0, r0, r0, 6'h08), 2, next_rand(), v, 1'b1);
        branch_case("jalr", r_word(ra, r0, rc, r0, 6'h09), 2, next_rand(), v, 1'b1);
        @(posedge clk);
        ex_fwd  <= '0;
        mem_fwd <= '0;
        $display("test branch_resolution done, %0d errors", errors - start);
    endtask

    task automatic stall_case(input string name, input logic load, input logic [4:0] wa,
                              input logic exp);
        @(posedge clk);
        ex_is_load <= load;
        ex_fwd     <= '{1'b1, wa, 32'h0};
        @(negedge clk);
        check_value({name, " stallreq"}, 32'(stallreq), 32'(exp));
    endtask

    task automatic load_use_stall();
        int start;
        start = errors;
        issue(32'h0000_1000, r_word(ra, rb, rc, r0, 6'h21));
        stall_case("match rs", 1'b1, ra, 1'b1);
        stall_case("match rt", 1'b1, rb, 1'b1);
        stall_case("no match", 1'b1, 5'd7, 1'b0);
        stall_case("not load", 1'b0, ra, 1'b0);
        issue(32'h0000_1004, r_word(r0, r0, rc, r0, 6'h21));
        stall_case("zero addr", 1'b1, r0, 1'b0);
        @(posedge clk);
        ex_is_load <= 1'b0;
        ex_fwd     <= '0;
        $display("test load_use_stall done, %0d errors", errors - start);
    endtask

    task automatic hold_and_bubble();
        int          start;
        logic [31:0] word;
        start = errors;
        word = i_word(6'h23, ra, rb, 16'h0008);
        issue(32'h0000_2000, word);
        @(posedge clk);
        stall.id_hold <= 1'b1;
        stall.if_hold <= 1'b1;
        @(posedge clk);
        inst_sram_rdata <= next_rand();
        if_to_id.pc     <= 32'h0000_2004;
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            check_value("held pc", id_to_ex.pc, 32'h0000_2000);
            check_value("held inst", id_to_ex.inst, word);
            @(posedge clk);
            inst_sram_rdata <= next_rand();
        end
        stall.id_hold <= 1'b0;
        // a jump waits on the sram side of the bubble
        inst_sram_rdata <= {6'h02, 26'h0000040};
        @(posedge clk);
        @(negedge clk);
        check_value("bubble pc", id_to_ex.pc, 32'd0);
        check_value("bubble inst", id_to_ex.inst, 32'd0);
        check_value("bubble mem_en", 32'(id_to_ex.ctrl.mem_en), 32'd0);
        check_value("bubble taken", 32'(br.taken), 32'd0);
        @(posedge clk);
        stall <= '0;
        $display("test hold_and_bubble done, %0d errors", errors - start);
    endtask

    initial begin
        errors          = 0;
        checks          = 0;
        seed            = 32'd31;
        rst             <= 1'b1;
        stall           <= '0;
        if_to_id        <= '0;
        inst_sram_rdata <= '0;
        ex_fwd          <= '0;
        mem_fwd         <= '0;
        wb_fwd          <= '0;
        ex_is_load      <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset inst", id_to_ex.inst, 32'd0);
        check_value("reset taken", 32'(br.taken), 32'd0);
        check_value("reset stallreq", 32'(stallreq), 32'd0);
        check_value("reset mem_en", 32'(id_to_ex.ctrl.mem_en), 32'd0);
        decode_table();
        regfile_bypass();
        branch_resolution();
        load_use_stall();
        hold_and_bubble();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== id_stage.f ====
id_pkg.sv
id_fetch_latch.sv
id_control.sv
id_regfile.sv
id_branch_unit.sv
id_stage.sv
tb_id_stage.sv

// ==== Makefile ====
.PHONY: all run lint clean

all: run

run:
	verilator --binary -sv --top-module tb_id_stage -f id_stage.f -o sim_id_stage
	out=$$(./obj_dir/sim_id_stage); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only --timing -sv --top-module tb_id_stage -f id_stage.f
	verilator --lint-only -sv --top-module id_stage id_pkg.sv id_fetch_latch.sv \
		id_control.sv id_regfile.sv id_branch_unit.sv id_stage.sv

clean:
	rm -rf obj_dir
